// ==== Bender.yml ====
package:
  name: icache

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_array_if.sv
  - rtl/icache_refill_if.sv
  - rtl/icache_arrays.sv
  - rtl/icache_refill.sv
  - rtl/icache_ctrl.sv
  - rtl/icache_top.sv
  - target: test
    files:
      - tb/icache_mem_model.sv
      - tb/icache_tb.sv

// ==== rtl/icache_array_if.sv ====
`timescale 1ns/1ps

interface icache_array_if
	import icache_pkg::*;
	();

	logic rd_en;
	logic [index_w-1:0] rd_index;
	logic [num_ways-1:0] rd_valid;
	logic [num_ways-1:0][tag_w-1:0] rd_tag;
	logic [num_ways-1:0][line_w-1:0] rd_line;
	logic [way_w-1:0] rd_lru; // most recently used way

	logic wr_en;
	logic [index_w-1:0] wr_index;
	logic [way_w-1:0] wr_way;
	logic [tag_w-1:0] wr_tag;
	logic [line_w-1:0] wr_line;

	logic touch_en;
	logic [way_w-1:0] touch_way;
	logic flush;

	modport ctrl (
		output rd_en, rd_index, wr_en, wr_index, wr_way, wr_tag, wr_line,
		output touch_en, touch_way, flush,
		input rd_valid, rd_tag, rd_line, rd_lru
	);

	modport array (
		input rd_en, rd_index, wr_en, wr_index, wr_way, wr_tag, wr_line,
		input touch_en, touch_way, flush,
		output rd_valid, rd_tag, rd_line, rd_lru
	);

endinterface

// ==== rtl/icache_arrays.sv ====
`timescale 1ns/1ps

module icache_arrays
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	icache_array_if.array arr
);

	logic [tag_w-1:0] tag_mem [num_ways][num_sets];
	logic [line_w-1:0] data_mem [num_ways][num_sets];
	logic [num_ways-1:0][num_sets-1:0] valid;
	logic [num_sets-1:0] lru; // way last used, per set

	// valid and lru bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
			lru <= '0;
		end else if (arr.flush) begin
			valid <= '0; // fence.i
			lru <= '0;
		end else begin
			if (arr.touch_en)
				lru[arr.rd_index] <= arr.touch_way;
			if (arr.wr_en) begin
				valid[arr.wr_way][arr.wr_index] <= 1'b1;
				lru[arr.wr_index] <= arr.wr_way; // new line counts as recent
			end
		end
	end

	// line write into one way
	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (arr.wr_en && arr.wr_way == way_w'(w)) begin
				tag_mem[w][arr.wr_index] <= arr.wr_tag;
				data_mem[w][arr.wr_index] <= arr.wr_line;
			end
		end
	end

	// registered read of both ways, held until next rd_en
	always_ff @(posedge clk) begin
		if (arr.rd_en) begin
			for (int w = 0; w < num_ways; w++) begin
				arr.rd_valid[w] <= valid[w][arr.rd_index];
				arr.rd_tag[w] <= tag_mem[w][arr.rd_index];
				arr.rd_line[w] <= data_mem[w][arr.rd_index];
			end
			arr.rd_lru <= lru[arr.rd_index];
		end
	end

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_req_valid,
	output logic cpu_req_ready,
	input logic [addr_w-1:0] cpu_req_addr,
	output logic cpu_resp_valid,
	output logic [data_w-1:0] cpu_resp_data,
	input logic flush,
	icache_array_if.ctrl arr,
	icache_refill_if.ctrl rfl
);

	icache_state_e state, state_nxt;
	logic flush_pending;
	logic [addr_w-1:0] req_addr;
	logic [way_w-1:0] victim_q;
	logic [tag_w-1:0] req_tag;
	logic [index_w-1:0] req_index;
	logic [offset_w-1:0] req_word;
	logic hit;
	logic [way_w-1:0] hit_idx;
	logic req_fire;

	assign req_tag = req_addr[tag_lsb +: tag_w];
	assign req_index = req_addr[index_lsb +: index_w];
	assign req_word = req_addr[offset_lsb +: offset_w];

	assign cpu_req_ready = (state == idle) && !flush && !flush_pending;
	assign req_fire = cpu_req_valid && cpu_req_ready;

	// tag compare on the registered read
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (arr.rd_valid[w] && arr.rd_tag[w] == req_tag) begin
				hit = 1'b1;
				hit_idx = way_w'(w);
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			idle: if (req_fire) state_nxt = lookup;
			lookup: state_nxt = compare;
			compare: state_nxt = hit ? idle : refill;
			refill: if (!rfl.busy) state_nxt = install;
			install: if (rfl.done) state_nxt = lookup; // re-read for the response
			default: state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			flush_pending <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == idle)
				flush_pending <= 1'b0; // applied now
			else if (flush)
				flush_pending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire)
			req_addr <= cpu_req_addr;
		// invalid way first, then the one not used last
		if (state == compare && !hit) begin
			if (!arr.rd_valid[0])
				victim_q <= 1'b0;
			else if (!arr.rd_valid[1])
				victim_q <= 1'b1;
			else
				victim_q <= ~arr.rd_lru;
		end
	end

	assign cpu_resp_valid = (state == compare) && hit;
	assign cpu_resp_data = arr.rd_line[hit_idx][req_word * data_w +: data_w];

	assign arr.rd_en = (state == lookup);
	assign arr.rd_index = req_index;
	assign arr.touch_en = cpu_resp_valid;
	assign arr.touch_way = hit_idx;
	assign arr.flush = (state == idle) && (flush || flush_pending);

	assign arr.wr_en = (state == install) && rfl.done;
	assign arr.wr_index = req_index;
	assign arr.wr_way = victim_q;
	assign arr.wr_tag = req_tag;
	assign arr.wr_line = rfl.line;

	assign rfl.start = (state == refill) && !rfl.busy;
	assign rfl.line_addr = {req_addr[addr_w-1:index_lsb], {index_lsb{1'b0}}}; // line aligned

endmodule

// ==== rtl/icache_pkg.sv ====
package icache_pkg;

	// address and data widths
	localparam int addr_w = 64;
	localparam int data_w = 64;

	// geometry
	localparam int num_sets = 64;
	localparam int index_w = 6;
	localparam int num_ways = 2;
	localparam int way_w = 1;
	localparam int words_per_line = 4;
	localparam int offset_w = 2; // word select
	localparam int line_w = 256;
	localparam int tag_w = 53;

	// field positions in the fetch address
	localparam int offset_lsb = 3;
	localparam int index_lsb = offset_lsb + offset_w;
	localparam int tag_lsb = index_lsb + index_w;

	typedef enum logic [2:0] {
		idle,
		lookup,
		compare,
		refill, // launch burst
		install // wait for line, write it
	} icache_state_e;

endpackage

// ==== rtl/icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	icache_refill_if.refill rfl,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output logic [addr_w-1:0] mem_req_addr,
	input logic mem_resp_valid,
	input logic [data_w-1:0] mem_resp_data
);

	logic [offset_w-1:0] beat_cnt;
	logic beat_fire;

	// beats only count once the request is out
	assign beat_fire = rfl.busy && !mem_req_valid && mem_resp_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_req_valid <= 1'b0;
			rfl.busy <= 1'b0;
			rfl.done <= 1'b0;
			beat_cnt <= '0;
		end else begin
			rfl.done <= 1'b0;
			if (rfl.start) begin
				mem_req_valid <= 1'b1;
				rfl.busy <= 1'b1;
				beat_cnt <= '0;
			end else if (mem_req_valid && mem_req_ready) begin
				mem_req_valid <= 1'b0; // accepted
			end
			if (beat_fire) begin
				beat_cnt <= beat_cnt + 1'b1;
				if (beat_cnt == offset_w'(words_per_line - 1)) begin
					rfl.busy <= 1'b0;
					rfl.done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rfl.start)
			mem_req_addr <= rfl.line_addr;
		// first beat ends up in word 0
		if (beat_fire)
			rfl.line <= {mem_resp_data, rfl.line[line_w-1:data_w]};
	end

endmodule

// ==== rtl/icache_refill_if.sv ====
`timescale 1ns/1ps

interface icache_refill_if
	import icache_pkg::*;
	();

	logic start; // one cycle
	logic [addr_w-1:0] line_addr;
	logic busy;
	logic done; // one cycle, line valid with it
	logic [line_w-1:0] line;

	modport ctrl (
		output start, line_addr,
		input busy, done, line
	);

	modport refill (
		input start, line_addr,
		output busy, done, line
	);

endinterface

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top
	import icache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_req_valid,
	output logic cpu_req_ready,
	input logic [addr_w-1:0] cpu_req_addr,
	output logic cpu_resp_valid,
	output logic [data_w-1:0] cpu_resp_data,
	input logic flush,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output logic [addr_w-1:0] mem_req_addr,
	input logic mem_resp_valid,
	input logic [data_w-1:0] mem_resp_data
);

	icache_array_if arr_if ();
	icache_refill_if rfl_if ();

	icache_ctrl i_icache_ctrl (
		.clk (clk),
		.rst_n (rst_n),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_ready (cpu_req_ready),
		.cpu_req_addr (cpu_req_addr),
		.cpu_resp_valid (cpu_resp_valid),
		.cpu_resp_data (cpu_resp_data),
		.flush (flush),
		.arr (arr_if.ctrl),
		.rfl (rfl_if.ctrl)
	);

	icache_arrays i_icache_arrays (
		.clk (clk),
		.rst_n (rst_n),
		.arr (arr_if.array)
	);

	icache_refill i_icache_refill (
		.clk (clk),
		.rst_n (rst_n),
		.rfl (rfl_if.refill),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req_addr (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data (mem_resp_data)
	);

endmodule

// ==== sim.f ====
rtl/icache_pkg.sv
rtl/icache_array_if.sv
rtl/icache_refill_if.sv
rtl/icache_arrays.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/icache_mem_model.sv
tb/icache_tb.sv

// ==== tb/icache_mem_model.sv ====
`timescale 1ns/1ps

module icache_mem_model (
	input logic clk,
	input logic rst_n,
	input logic mem_req_valid,
	output logic mem_req_ready,
	input logic [63:0] mem_req_addr,
	output logic mem_resp_valid,
	output logic [63:0] mem_resp_data
);

	localparam logic [63:0] data_key = 64'hfeed_0000_0000_0000;
	localparam int max_lat = 6;
	localparam int max_gap = 3; // idle cycles before a beat

	logic [63:0] line_addr;

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	initial begin
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		forever begin
			step();
			if (rst_n && mem_req_valid) begin
				repeat ($urandom_range(max_lat, 0)) step();
				line_addr = mem_req_addr;
				// random ready stalls, taken on the edge after ready goes high
				while (!mem_req_ready) begin
					mem_req_ready = ($urandom_range(2, 0) != 0);
					step();
				end
				mem_req_ready = 1'b0;
				for (int b = 0; b < 4; b++) begin
					repeat ($urandom_range(max_gap, 0)) step();
					mem_resp_valid = 1'b1;
					mem_resp_data = (line_addr + 64'(b * 8)) ^ data_key;
					step();
					mem_resp_valid = 1'b0;
				end
			end
		end
	end

endmodule

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb
	import icache_pkg::*;
();

	localparam logic [data_w-1:0] data_key = 64'hfeed_0000_0000_0000;
	localparam int timeout = 200; // cycles per wait
	localparam logic [31:0] seed = 32'h13da;
	localparam logic [addr_w-1:0] addr_a = {53'h100, 6'd5, 2'd1, 3'b000};
	localparam logic [addr_w-1:0] addr_b = {53'h200, 6'd5, 2'd3, 3'b000};
	localparam logic [addr_w-1:0] addr_c = {53'h300, 6'd5, 2'd0, 3'b000};

	logic clk = 1'b0;
	logic rst_n, cpu_req_valid, cpu_req_ready, cpu_resp_valid, flush;
	logic mem_req_valid, mem_req_ready, mem_resp_valid;
	logic [addr_w-1:0] cpu_req_addr, mem_req_addr, last_req_addr;
	logic [data_w-1:0] cpu_resp_data, mem_resp_data;
	logic [tag_w-1:0] m_tag [64][2]; // expected cache contents
	bit m_valid [64][2];
	bit m_lru [64]; // way used last
	int errors = 0;
	int mem_reqs = 0;
	int misses = 0; // predicted
	int tests_failed = 0;

	always #5 clk = ~clk;

	icache_top i_icache_top (.*);
	icache_mem_model i_mem_model (.*);

	always @(posedge clk) begin
		if (rst_n && mem_req_valid && mem_req_ready) begin
			mem_reqs <= mem_reqs + 1;
			last_req_addr <= mem_req_addr;
		end
	end

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run(input string what);
		$display("TIMEOUT t=%0t %s, controller in state %s", $time, what,
			i_icache_top.i_icache_ctrl.state.name());
		$display("tests failed");
		$finish;
	endtask

	task automatic mismatch(input string sig, input logic [63:0] exp_val, act_val);
		errors++;
		$display("MISMATCH t=%0t %s expected %h actual %h", $time, sig, exp_val, act_val);
	endtask

	task automatic failure(input string what);
		errors++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!cpu_req_ready) begin
			if (++n > timeout)
				abort_run("cpu_req_ready stayed low");
			tick();
		end
	endtask

	function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] tag,
		input int set, input int word);
		return {tag, 6'(set), 2'(word), 3'b000};
	endfunction

	// hit or miss, and update of the expected contents
	function automatic bit model_access(input logic [addr_w-1:0] a);
		int s;
		int w;
		s = a[10:5];
		for (w = 0; w < 2; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == a[63:11]) begin
				m_lru[s] = w[0];
				return 1'b1;
			end
		end
		w = !m_valid[s][0] ? 0 : !m_valid[s][1] ? 1 : int'(!m_lru[s]); // invalid way first
		m_valid[s][w] = 1'b1;
		m_tag[s][w] = a[63:11];
		m_lru[s] = w[0];
		return 1'b0;
	endfunction

	task automatic fetch(input logic [addr_w-1:0] a);
		logic [data_w-1:0] exp_data;
		bit hit;
		int reqs;
		int n;
		hit = model_access(a);
		exp_data = {a[63:3], 3'b000} ^ data_key;
		reqs = mem_reqs;
		wait_ready();
		cpu_req_valid = 1'b1;
		cpu_req_addr = a;
		tick();
		cpu_req_valid = 1'b0;
		n = 1; // cycles since accept
		while (!cpu_resp_valid) begin
			if (++n > timeout)
				abort_run($sformatf("no response to fetch of %h", a));
			tick();
		end
		assert (cpu_resp_data === exp_data)
			else mismatch("cpu_resp_data", exp_data, cpu_resp_data);
		assert (mem_reqs - reqs == (hit ? 0 : 1))
			else failure($sformatf("fetch of %h made %0d memory requests, predicted hit %0b",
				a, mem_reqs - reqs, hit));
		if (hit) begin
			assert (n == 2)
				else failure($sformatf("hit on %h answered %0d cycles after accept", a, n));
		end else begin
			misses++;
			assert (last_req_addr === {a[63:5], 5'b0})
				else mismatch("mem_req_addr", {a[63:5], 5'b0}, last_req_addr);
		end
	endtask

	task automatic flush_cache();
		wait_ready();
		flush = 1'b1;
		tick();
		flush = 1'b0;
		m_valid = '{default: 1'b0};
		m_lru = '{default: 1'b0};
		#1;
		assert (cpu_req_ready)
			else failure("cpu_req_ready not back one cycle after flush");
	endtask

	task automatic close_test(input string name, input int errors_before);
		if (errors != errors_before)
			tests_failed++;
		$display("%-22s %s", name, errors == errors_before ? "ok" : "FAIL");
	endtask

	task automatic cold_miss_then_hit();
		int e;
		e = errors;
		fetch(make_addr(53'h42, 3, 2));
		for (int w = 0; w < 4; w++)
			if (w != 2)
				fetch(make_addr(53'h42, 3, w)); // rest of the line, all hits
		close_test("cold miss then hit", e);
	endtask

	task automatic two_way_placement();
		int e;
		e = errors;
		fetch(addr_a);
		fetch(addr_b);
		fetch(addr_a);
		fetch(addr_b);
		close_test("two way placement", e);
	endtask

	task automatic lru_replacement();
		int e;
		e = errors;
		fetch(addr_a); // a now recent
		fetch(addr_c); // b is the victim
		fetch(addr_a);
		fetch(addr_b);
		close_test("lru replacement", e);
	endtask

	task automatic flush_all();
		int e;
		e = errors;
		flush_cache();
		fetch(addr_a);
		fetch(addr_b);
		fetch(make_addr(53'h42, 3, 0));
		close_test("flush", e);
	endtask

	task automatic random_fetches();
		int e;
		int m;
		int reqs;
		e = errors;
		m = misses;
		reqs = mem_reqs;
		// few tags over few sets, so lines keep getting evicted
		for (int i = 0; i < 50; i++)
			fetch(make_addr(53'h500 + $urandom_range(3, 0), 8 + $urandom_range(2, 0),
				$urandom_range(3, 0)));
		assert (mem_reqs - reqs == misses - m)
			else failure($sformatf("%0d memory requests for %0d predicted misses",
				mem_reqs - reqs, misses - m));
		close_test("random back-pressure", e);
	endtask

	initial begin
		void'($urandom(seed));
		rst_n = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_addr = '0;
		flush = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		cold_miss_then_hit();
		two_way_placement();
		lru_replacement();
		flush_all();
		random_fetches();
		$display("5 tests run, %0d failed, %0d errors", tests_failed, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
